/* logic/dcache_controller.sv */
`timescale 1ns/100ps

module dcache_controller #(
   parameter int INDEX_WIDTH       = 4,
   parameter int OFFSET_WIDTH      = 5,
   parameter int BUS_ADDRESS_WIDTH = 20
) (
   input  logic                                                   clk_i,
   input  logic                                                   rst_i,
   input  dcache_pkg::word_addr_t                                 addr_i,
   input  dcache_pkg::word_t                                      data_i,
   input  dcache_pkg::byte_en_t                                   write_en_i,
   input  logic                                                   en_i,
   output dcache_pkg::word_t                                      data_o,
   output logic                                                   blocking_n_o,
   output logic                                                   flushing_n_o,
   output logic [BUS_ADDRESS_WIDTH-dcache_pkg::QWORD_SHIFT-1:0]   bus_addr_o,
   output dcache_pkg::qword_t                                     bus_data_o,
   output logic                                                   bus_we_o,
   output logic                                                   bus_valid_o,
   input  dcache_pkg::qword_t                                     bus_data_i,
   input  logic                                                   bus_valid_i,
   output logic [2**INDEX_WIDTH-1:0]                              line_wr_en_o,
   output logic [OFFSET_WIDTH-1:0]                                wr_offset_o,
   output dcache_pkg::cpu_wr_t                                    wr_o,
   output logic [OFFSET_WIDTH-1:0]                                rd_offset_o,
   output logic [2**INDEX_WIDTH-1:0]                              fill_en_o,
   output logic [OFFSET_WIDTH-dcache_pkg::QWORD_SHIFT+1:0]        fill_idx_o,
   output dcache_pkg::qword_t                                     fill_data_o,
   output logic [OFFSET_WIDTH-dcache_pkg::QWORD_SHIFT+1:0]        q_idx_o,
   input  dcache_pkg::word_t                                      line_word_i [2**INDEX_WIDTH],
   input  dcache_pkg::qword_t                                     line_qword_i [2**INDEX_WIDTH],
   input  logic [2**(OFFSET_WIDTH-dcache_pkg::QWORD_SHIFT+2)-1:0] line_dirty_i [2**INDEX_WIDTH]
);
   import dcache_pkg::*;

   localparam int WSEL_WIDTH = QWORD_SHIFT - 2;
   localparam int QIDX_WIDTH = OFFSET_WIDTH - WSEL_WIDTH;
   localparam int BLOCKS     = 2 ** INDEX_WIDTH;
   localparam int TAG_LSB    = OFFSET_WIDTH + INDEX_WIDTH;  // Counted in word address bits
   localparam int TAG_WIDTH  = BUS_ADDRESS_WIDTH - 2 - TAG_LSB;
   localparam int BYTES      = $bits(byte_en_t);

   typedef logic [TAG_WIDTH-1:0]    tag_t;
   typedef logic [INDEX_WIDTH-1:0]  index_t;
   typedef logic [OFFSET_WIDTH-1:0] offset_t;
   typedef logic [QIDX_WIDTH-1:0]   qidx_t;

   tag_t    tag;
   index_t  index;
   offset_t offset;

   tag_t              tag_q [BLOCKS];
   logic [BLOCKS-1:0] valid_q;

   dcache_state_t state_q;
   qidx_t         q_cnt;
   qidx_t         q_next;
   logic          q_last;     // Carry out, last quad-word reached
   qidx_t         q_sel;
   tag_t          old_tag;
   logic          old_valid;

   logic  hit;
   logic  accept;
   logic  miss_start;
   logic  refill_done;
   logic  wb_needed;
   word_t rd_word;

   assign tag    = addr_i[TAG_LSB +: TAG_WIDTH];
   assign index  = addr_i[OFFSET_WIDTH +: INDEX_WIDTH];
   assign offset = addr_i[OFFSET_WIDTH-1:0];

   assign hit          = valid_q[index] && (tag_q[index] == tag);
   assign blocking_n_o = (state_q == IDLE) && (hit || !en_i);
   assign accept       = en_i && blocking_n_o;
   assign miss_start   = (state_q == IDLE) && en_i && !hit;
   assign refill_done  = (state_q == STEP) && q_last;

   assign {q_last, q_next} = {1'b0, q_cnt} + 1'b1;

   // Dirty check for the quad-word the walk visits next
   assign q_sel     = (state_q == IDLE) ? '0 : q_next;
   assign wb_needed = ((state_q == IDLE) ? valid_q[index] : old_valid)
                      && line_dirty_i[index][q_sel];

   // Block store steering
   assign rd_offset_o = offset;
   assign wr_offset_o = offset;
   assign wr_o        = '{data: data_i, be: write_en_i};
   assign fill_idx_o  = q_cnt;
   assign fill_data_o = bus_data_i;
   assign q_idx_o     = q_cnt;
   assign rd_word     = line_word_i[index];

   always_comb begin
      line_wr_en_o = '0;
      fill_en_o    = '0;
      line_wr_en_o[index] = accept && (write_en_i != '0);
      fill_en_o[index]    = (state_q == FILL_REQ) && bus_valid_o && bus_valid_i;
   end

   // Old tag during write-back, new tag during fill
   assign bus_we_o   = (state_q == WB_REQ);
   assign bus_addr_o = {(state_q == WB_REQ) ? old_tag : tag, index, q_cnt};

   // Word as it stands after the access, written bytes merged in
   always_ff @(posedge clk_i) begin
      if (accept) begin
         for (int b = 0; b < BYTES; b++) begin
            data_o[b * 8 +: 8] <= write_en_i[b] ? data_i[b * 8 +: 8] : rd_word[b * 8 +: 8];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (miss_start) begin
         old_tag <= tag_q[index];
      end
      if ((state_q == WB_REQ) && !bus_valid_o) begin
         bus_data_o <= line_qword_i[index];  // Captured as the request goes out
      end
      if (refill_done) begin
         tag_q[index] <= tag;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q      <= IDLE;
         valid_q      <= '0;
         flushing_n_o <= 1'b1;
         bus_valid_o  <= 1'b0;
         q_cnt        <= '0;
         old_valid    <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (miss_start) begin
                  old_valid      <= valid_q[index];
                  valid_q[index] <= 1'b0;  // Block is in flux until the walk ends
                  q_cnt          <= '0;
                  flushing_n_o   <= 1'b0;
                  state_q        <= wb_needed ? WB_REQ : FILL_REQ;
               end
            end
            WB_REQ, FILL_REQ: begin
               if (!bus_valid_o) begin
                  bus_valid_o <= 1'b1;
               end else if (bus_valid_i) begin
                  bus_valid_o <= 1'b0;
                  state_q     <= (state_q == WB_REQ) ? FILL_REQ : STEP;
               end
            end
            STEP: begin
               if (q_last) begin
                  valid_q[index] <= 1'b1;
                  flushing_n_o   <= 1'b1;
                  state_q        <= IDLE;
               end else begin
                  q_cnt   <= q_next;
                  state_q <= wb_needed ? WB_REQ : FILL_REQ;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Bus request is held unchanged until acknowledged
   a_bus_hold : assert property (
      @(posedge clk_i) disable iff (rst_i)
      bus_valid_o && !bus_valid_i |=>
         bus_valid_o && $stable(bus_addr_o) && $stable(bus_we_o) && $stable(bus_data_o)
   );

   // Block stores are never written while a refill is under way
   a_no_write_blocked : assert property (
      @(posedge clk_i) disable iff (rst_i)
      (line_wr_en_o != '0) |-> flushing_n_o && !bus_valid_o
   );

endmodule

/* logic/dcache_line.sv */
`timescale 1ns/100ps

module dcache_line #(
   parameter int OFFSET_WIDTH = 5
) (
   input  logic                                               clk_i,
   input  logic                                               rst_i,
   input  logic                                               wr_en_i,
   input  logic [OFFSET_WIDTH-1:0]                            wr_offset_i,
   input  dcache_pkg::cpu_wr_t                                wr_i,
   input  logic [OFFSET_WIDTH-1:0]                            rd_offset_i,
   input  logic                                               fill_en_i,
   input  logic [OFFSET_WIDTH-dcache_pkg::QWORD_SHIFT+1:0]    fill_idx_i,
   input  dcache_pkg::qword_t                                 fill_data_i,
   input  logic [OFFSET_WIDTH-dcache_pkg::QWORD_SHIFT+1:0]    q_idx_i,
   output dcache_pkg::word_t                                  word_o,
   output dcache_pkg::qword_t                                 qword_o,
   output logic [2**(OFFSET_WIDTH-dcache_pkg::QWORD_SHIFT+2)-1:0] dirty_o
);
   import dcache_pkg::*;

   localparam int WSEL_WIDTH = QWORD_SHIFT - 2;  // Word select inside a quad-word
   localparam int QIDX_WIDTH = OFFSET_WIDTH - WSEL_WIDTH;
   localparam int QWORDS     = 2 ** QIDX_WIDTH;
   localparam int WORD_BITS  = $bits(word_t);
   localparam int BYTES      = $bits(byte_en_t);

   typedef logic [QIDX_WIDTH-1:0] qidx_t;
   typedef logic [WSEL_WIDTH-1:0] wsel_t;

   qword_t            mem [QWORDS];
   logic [QWORDS-1:0] dirty_q;

   qidx_t wr_q;
   wsel_t wr_w;
   qidx_t rd_q;
   wsel_t rd_w;

   assign wr_q = wr_offset_i[OFFSET_WIDTH-1:WSEL_WIDTH];
   assign wr_w = wr_offset_i[WSEL_WIDTH-1:0];
   assign rd_q = rd_offset_i[OFFSET_WIDTH-1:WSEL_WIDTH];
   assign rd_w = rd_offset_i[WSEL_WIDTH-1:0];

   // Refill replaces a whole quad-word, core writes touch enabled bytes only
   always_ff @(posedge clk_i) begin
      if (fill_en_i) begin
         mem[fill_idx_i] <= fill_data_i;
      end else if (wr_en_i) begin
         for (int b = 0; b < BYTES; b++) begin
            if (wr_i.be[b]) begin
               mem[wr_q][wr_w * WORD_BITS + b * 8 +: 8] <= wr_i.data[b * 8 +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         dirty_q <= '0;
      end else begin
         if (wr_en_i) begin
            dirty_q[wr_q] <= 1'b1;
         end
         if (fill_en_i) begin
            dirty_q[fill_idx_i] <= 1'b0;  // Fresh from memory
         end
      end
   end

   assign word_o  = mem[rd_q][rd_w * WORD_BITS +: WORD_BITS];
   assign qword_o = mem[q_idx_i];  // Write-back source
   assign dirty_o = dirty_q;

   // Controller only refills while the core is held
   a_no_write_during_fill : assert property (
      @(posedge clk_i) disable iff (rst_i) !(wr_en_i && fill_en_i)
   );

endmodule

/* logic/dcache_pkg.sv */
package dcache_pkg;

   // Bytes per bus transfer, as a power of two
   localparam int QWORD_SHIFT = 4;

   typedef logic [31:0] word_t;
   typedef logic [(2 ** QWORD_SHIFT) * 8 - 1:0] qword_t;  // Four words per bus beat
   typedef logic [3:0] byte_en_t;
   typedef logic [29:0] word_addr_t;  // Byte address without bits 1:0

   // Core write bundle, sent to every block store
   typedef struct packed {
      word_t    data;
      byte_en_t be;
   } cpu_wr_t;

   // Refill walk: WB_REQ writes the old quad-word back,
   // FILL_REQ reads the new one, STEP moves to the next
   typedef enum logic [1:0] {
      IDLE,
      WB_REQ,
      FILL_REQ,
      STEP
   } dcache_state_t;

endpackage

/* logic/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top #(
   parameter int INDEX_WIDTH       = 4,
   parameter int OFFSET_WIDTH      = 5,
   parameter int BUS_ADDRESS_WIDTH = 20
) (
   input  logic                                                 clk_i,
   input  logic                                                 rst_i,
   input  dcache_pkg::word_addr_t                               addr_i,
   input  dcache_pkg::word_t                                    data_i,
   input  dcache_pkg::byte_en_t                                 write_en_i,
   input  logic                                                 en_i,
   output dcache_pkg::word_t                                    data_o,
   output logic                                                 blocking_n_o,
   output logic                                                 flushing_n_o,
   output logic [BUS_ADDRESS_WIDTH-dcache_pkg::QWORD_SHIFT-1:0] bus_addr_o,
   output dcache_pkg::qword_t                                   bus_data_o,
   output logic                                                 bus_we_o,
   output logic                                                 bus_valid_o,
   input  dcache_pkg::qword_t                                   bus_data_i,
   input  logic                                                 bus_valid_i
);
   import dcache_pkg::*;

   localparam int QIDX_WIDTH = OFFSET_WIDTH - QWORD_SHIFT + 2;
   localparam int BLOCKS     = 2 ** INDEX_WIDTH;

   logic [BLOCKS-1:0]       line_wr_en;
   logic [BLOCKS-1:0]       fill_en;
   logic [OFFSET_WIDTH-1:0] wr_offset;
   logic [OFFSET_WIDTH-1:0] rd_offset;
   cpu_wr_t                 wr;
   logic [QIDX_WIDTH-1:0]   fill_idx;
   logic [QIDX_WIDTH-1:0]   q_idx;
   qword_t                  fill_data;

   // One entry per block
   word_t                    line_word [BLOCKS];
   qword_t                   line_qword [BLOCKS];
   logic [2**QIDX_WIDTH-1:0] line_dirty [BLOCKS];

   dcache_controller #(
      .INDEX_WIDTH(INDEX_WIDTH),
      .OFFSET_WIDTH(OFFSET_WIDTH),
      .BUS_ADDRESS_WIDTH(BUS_ADDRESS_WIDTH)
   ) dcache_controller_inst (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .addr_i(addr_i),
      .data_i(data_i),
      .write_en_i(write_en_i),
      .en_i(en_i),
      .data_o(data_o),
      .blocking_n_o(blocking_n_o),
      .flushing_n_o(flushing_n_o),
      .bus_addr_o(bus_addr_o),
      .bus_data_o(bus_data_o),
      .bus_we_o(bus_we_o),
      .bus_valid_o(bus_valid_o),
      .bus_data_i(bus_data_i),
      .bus_valid_i(bus_valid_i),
      .line_wr_en_o(line_wr_en),
      .wr_offset_o(wr_offset),
      .wr_o(wr),
      .rd_offset_o(rd_offset),
      .fill_en_o(fill_en),
      .fill_idx_o(fill_idx),
      .fill_data_o(fill_data),
      .q_idx_o(q_idx),
      .line_word_i(line_word),
      .line_qword_i(line_qword),
      .line_dirty_i(line_dirty)
   );

   for (genvar g = 0; g < BLOCKS; g++) begin : g_line
      dcache_line #(
         .OFFSET_WIDTH(OFFSET_WIDTH)
      ) dcache_line_inst (
         .clk_i(clk_i),
         .rst_i(rst_i),
         .wr_en_i(line_wr_en[g]),
         .wr_offset_i(wr_offset),
         .wr_i(wr),
         .rd_offset_i(rd_offset),
         .fill_en_i(fill_en[g]),
         .fill_idx_i(fill_idx),
         .fill_data_i(fill_data),
         .q_idx_i(q_idx),
         .word_o(line_word[g]),
         .qword_o(line_qword[g]),
         .dirty_o(line_dirty[g])
      );
   end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_dcache_top -f sim.f
./obj_dir/Vtb_dcache_top | tee sim.log

if grep -qx "Done: no errors" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

/* sim.f */
logic/dcache_pkg.sv
logic/dcache_line.sv
logic/dcache_controller.sv
logic/dcache_top.sv
test/bus_memory.sv
test/tb_dcache_top.sv

/* test/bus_memory.sv */
`timescale 1ns/100ps

module bus_memory #(
   parameter int ADDR_WIDTH = 16  // Quad-word address bits
) (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic [ADDR_WIDTH-1:0] addr_i,
   input  dcache_pkg::qword_t    wdata_i,
   input  logic                  we_i,
   input  logic                  req_i,
   output dcache_pkg::qword_t    rdata_o,
   output logic                  ack_o,
   output int                    read_count_o,
   output int                    write_count_o,
   input  logic [ADDR_WIDTH-1:0] peek_addr_i,
   output dcache_pkg::qword_t    peek_qword_o
);
   import dcache_pkg::*;

   localparam int WORDS     = $bits(qword_t) / $bits(word_t);
   localparam int WORD_BITS = $bits(word_t);

   qword_t mem [2**ADDR_WIDTH];
   integer seed;
   int     delay;
   logic   pending;

   assign peek_qword_o = mem[peek_addr_i];

   initial begin
      seed          = 87517;
      ack_o         = 1'b0;
      rdata_o       = '0;
      pending       = 1'b0;
      delay         = 0;
      read_count_o  = 0;
      write_count_o = 0;
      // Scrambled word address in every word
      for (int a = 0; a < 2**ADDR_WIDTH; a++) begin
         for (int k = 0; k < WORDS; k++) begin
            mem[a][k * WORD_BITS +: WORD_BITS] = (a * WORDS + k) * 32'h9e3779b1 + 32'h13579bdf;
         end
      end
      forever begin
         @(posedge clk_i);
         #1;
         if (rst_i) begin
            ack_o   = 1'b0;
            pending = 1'b0;
         end else if (ack_o) begin
            ack_o = 1'b0;  // One-cycle pulse
         end else if (req_i) begin
            if (!pending) begin
               pending = 1'b1;
               delay   = {$random(seed)} % 6;
            end
            if (delay == 0) begin
               pending = 1'b0;
               ack_o   = 1'b1;
               if (we_i) begin
                  mem[addr_i] = wdata_i;
                  write_count_o++;
               end else begin
                  rdata_o = mem[addr_i];
                  read_count_o++;
               end
            end else begin
               delay--;
            end
         end
      end
   end

endmodule

/* test/tb_dcache_top.sv */
`timescale 1ns/100ps

module tb_dcache_top;
   import dcache_pkg::*;

   localparam int INDEX_WIDTH       = 4;
   localparam int OFFSET_WIDTH      = 5;
   localparam int BUS_ADDRESS_WIDTH = 20;
   localparam int QADDR_WIDTH       = BUS_ADDRESS_WIDTH - QWORD_SHIFT;
   localparam int TAG_LSB           = OFFSET_WIDTH + INDEX_WIDTH;
   localparam int BLOCKS            = 2 ** INDEX_WIDTH;
   localparam int BLOCK_WORDS       = 2 ** OFFSET_WIDTH;
   localparam int QWORD_WORDS       = 2 ** (QWORD_SHIFT - 2);
   localparam int QWORDS            = BLOCK_WORDS / QWORD_WORDS;
   // Per quad-word a write and a read of up to 7 cycles each, plus a step
   localparam int REFILL_CYCLES     = QWORDS * (2 * 7 + 1);
   localparam int MAX_ACCESSES      = 240;  // About 220 accesses, any may refill
   localparam int TIMEOUT_CYCLES    = MAX_ACCESSES * (REFILL_CYCLES + 3) + 500;

   logic clk = 1'b0;
   logic rst;
   word_addr_t addr;
   word_t      wdata;
   word_t      rdata;
   byte_en_t   be;
   logic       en;
   logic       blocking_n;
   logic       flushing_n;
   logic [QADDR_WIDTH-1:0] bus_addr;
   logic [QADDR_WIDTH-1:0] peek_addr;
   qword_t     bus_wdata;
   qword_t     bus_rdata;
   qword_t     peek_qword;
   logic       bus_we;
   logic       bus_req;
   logic       bus_ack;
   int         read_count;
   int         write_count;

   // Reference model of memory and of the tag store
   word_t             model_mem [int];
   int                model_tag [BLOCKS];
   logic [BLOCKS-1:0] model_valid;
   logic [QWORDS-1:0] model_dirty [BLOCKS];
   int     exp_reads  = 0;
   int     exp_writes = 0;
   int     errors     = 0;
   int     checks     = 0;
   int     cycles     = 0;
   integer seed;

   always #2 clk = ~clk;

   dcache_top #(
      .INDEX_WIDTH(INDEX_WIDTH),
      .OFFSET_WIDTH(OFFSET_WIDTH),
      .BUS_ADDRESS_WIDTH(BUS_ADDRESS_WIDTH)
   ) dcache_top_inst (
      .clk_i(clk), .rst_i(rst),
      .addr_i(addr), .data_i(wdata), .write_en_i(be), .en_i(en),
      .data_o(rdata), .blocking_n_o(blocking_n), .flushing_n_o(flushing_n),
      .bus_addr_o(bus_addr), .bus_data_o(bus_wdata), .bus_we_o(bus_we),
      .bus_valid_o(bus_req), .bus_data_i(bus_rdata), .bus_valid_i(bus_ack)
   );

   bus_memory #(
      .ADDR_WIDTH(QADDR_WIDTH)
   ) bus_memory_inst (
      .clk_i(clk), .rst_i(rst),
      .addr_i(bus_addr), .wdata_i(bus_wdata), .we_i(bus_we), .req_i(bus_req),
      .rdata_o(bus_rdata), .ack_o(bus_ack),
      .read_count_o(read_count), .write_count_o(write_count),
      .peek_addr_i(peek_addr), .peek_qword_o(peek_qword)
   );

   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Done: errors found");
         $finish;
      end
   end

   function automatic word_t initial_word(input int w);
      return w * 32'h9e3779b1 + 32'h13579bdf;  // Same scramble as the bus memory fill
   endfunction

   function automatic word_t model_word(input int w);
      if (model_mem.exists(w)) begin
         return model_mem[w];
      end
      return initial_word(w);
   endfunction

   function automatic word_addr_t make_addr(input int tag, input int idx, input int off);
      return word_addr_t'((tag << TAG_LSB) | (idx << OFFSET_WIDTH) | off);
   endfunction

   task automatic expect_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // One core access, held until accepted, then checked against the model
   task automatic access(input word_addr_t a, input word_t d, input byte_en_t b);
      int    w;
      int    idx;
      int    tag;
      logic  miss;
      logic  saw_flush;
      word_t exp_word;
      w    = int'(a);
      idx  = (w >> OFFSET_WIDTH) % BLOCKS;
      tag  = w >> TAG_LSB;
      miss = !model_valid[idx] || (model_tag[idx] != tag);
      if (miss) begin
         exp_reads += QWORDS;
         if (model_valid[idx]) begin
            exp_writes += $countones(model_dirty[idx]);  // Only dirty quad-words go back
         end
         model_valid[idx] = 1'b1;
         model_tag[idx]   = tag;
         model_dirty[idx] = '0;
      end
      exp_word = model_word(w);
      for (int i = 0; i < 4; i++) begin
         if (b[i]) begin
            exp_word[i * 8 +: 8] = d[i * 8 +: 8];
         end
      end
      if (b != '0) begin
         model_mem[w] = exp_word;
         model_dirty[idx][(w % BLOCK_WORDS) / QWORD_WORDS] = 1'b1;
      end
      @(posedge clk);
      #1;
      addr      = a;
      wdata     = d;
      be        = b;
      en        = 1'b1;
      saw_flush = 1'b0;
      @(negedge clk);
      while (!blocking_n) begin
         if (!flushing_n) begin
            saw_flush = 1'b1;
         end
         @(negedge clk);
      end
      expect_value("refill seen on flushing_n_o", 32'(saw_flush), 32'(miss));
      expect_value("flushing_n_o at accept", 32'(flushing_n), 32'h1);
      @(posedge clk);  // Accepting edge
      #1;
      en = 1'b0;
      be = '0;
      @(negedge clk);
      expect_value("data_o", rdata, exp_word);
      expect_value("bus read count", read_count, exp_reads);
      expect_value("bus write count", write_count, exp_writes);
   endtask

   task automatic check_block_memory(input int tag, input int idx);
      int base;
      base = int'(make_addr(tag, idx, 0));
      for (int q = 0; q < QWORDS; q++) begin
         peek_addr = QADDR_WIDTH'(base / QWORD_WORDS + q);
         #1;
         for (int k = 0; k < QWORD_WORDS; k++) begin
            expect_value("bus memory word", peek_qword[k * 32 +: 32],
                         model_word(base + q * QWORD_WORDS + k));
         end
      end
   endtask

   task automatic reset_and_cold_miss();
      @(negedge clk);
      expect_value("bus_valid_o after reset", 32'(bus_req), 32'h0);
      expect_value("flushing_n_o after reset", 32'(flushing_n), 32'h1);
      access(make_addr(1, 3, 7), '0, '0);
   endtask

   task automatic byte_enable_writes();
      access(make_addr(1, 3, 7), 32'haabbccdd, 4'b0001);
      access(make_addr(1, 3, 7), 32'h11223344, 4'b0110);
      access(make_addr(1, 3, 8), 32'h55667788, 4'b1000);
      access(make_addr(1, 3, 31), 32'hdeadbeef, 4'b1111);
      access(make_addr(1, 3, 7), '0, '0);
      access(make_addr(1, 3, 8), '0, '0);
   endtask

   task automatic dirty_eviction();
      int writes_before;
      access(make_addr(2, 6, 0), '0, '0);
      access(make_addr(2, 6, 5), 32'h0badf00d, 4'b1111);   // Quad-word 1
      access(make_addr(2, 6, 22), 32'h12345678, 4'b0011);  // Quad-word 5
      writes_before = write_count;
      access(make_addr(9, 6, 0), '0, '0);
      expect_value("write-backs on dirty eviction", write_count - writes_before, 2);
      check_block_memory(2, 6);
      access(make_addr(2, 6, 5), '0, '0);
      access(make_addr(2, 6, 22), '0, '0);
   endtask

   task automatic clean_eviction();
      int reads_before;
      int writes_before;
      reads_before  = read_count;
      writes_before = write_count;
      access(make_addr(4, 6, 3), '0, '0);
      expect_value("reads on clean eviction", read_count - reads_before, QWORDS);
      expect_value("writes on clean eviction", write_count - writes_before, 0);
   endtask

   task automatic idle_enable();
      int reads_before;
      int writes_before;
      reads_before  = read_count;
      writes_before = write_count;
      @(posedge clk);
      #1;
      addr = make_addr(7, 6, 0);  // Would miss if enabled
      repeat (50) begin
         @(negedge clk);
         expect_value("bus_valid_o while idle", 32'(bus_req), 32'h0);
         expect_value("blocking_n_o while idle", 32'(blocking_n), 32'h1);
      end
      expect_value("reads while idle", read_count - reads_before, 0);
      expect_value("writes while idle", write_count - writes_before, 0);
      access(make_addr(1, 3, 7), '0, '0);
      access(make_addr(1, 3, 31), '0, '0);
   endtask

   task automatic random_traffic();
      int       tags [3] = '{5, 6, 5};
      int       idxs [3] = '{9, 9, 10};
      int       pick;
      int       off;
      word_t    d;
      byte_en_t b;
      for (int n = 0; n < 200; n++) begin
         pick = {$random(seed)} % 3;
         off  = {$random(seed)} % BLOCK_WORDS;
         d    = $random(seed);
         b    = ($random(seed) & 1) ? byte_en_t'($random(seed)) : '0;
         access(make_addr(tags[pick], idxs[pick], off), d, b);
      end
      // Push every touched block out to memory
      access(make_addr(7, 9, 0), '0, '0);
      access(make_addr(7, 10, 0), '0, '0);
      for (int i = 0; i < 3; i++) begin
         check_block_memory(tags[i], idxs[i]);
      end
   endtask

   initial begin
      seed        = 87517;
      rst         = 1'b1;
      en          = 1'b0;
      addr        = '0;
      wdata       = '0;
      be          = '0;
      peek_addr   = '0;
      model_valid = '0;
      for (int i = 0; i < BLOCKS; i++) begin
         model_tag[i]   = 0;
         model_dirty[i] = '0;
      end
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      reset_and_cold_miss();
      byte_enable_writes();
      dirty_eviction();
      clean_eviction();
      idle_enable();
      random_traffic();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule
